/* Makefile */
TOOL     = verilator
TOP      = tb_cache
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/cache_ctrl.sv */
// Cache controller FSM for lookup, dirty victim write-back, refill and response
// A miss refills the block, installs the tag and then replays as a hit
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,      // One-cycle strobe
    input  cache_req_t           req,
    output logic                 resp_valid,
    output cache_resp_t          resp,
    output logic                 busy,
    output logic [`ADDR_W-1:0]   lookup_addr,
    input  logic                 hit,
    input  logic [`WAY_W-1:0]    hit_way,
    input  logic [`WAY_W-1:0]    victim_way,
    input  tag_entry_t           victim_entry,
    output logic                 tag_we,
    output logic [`WAY_W-1:0]    tag_way,
    output tag_entry_t           tag_wentry,
    output logic [`WAY_W-1:0]    lfsr_bits,
    output logic [`WAY_W-1:0]    sram_way,
    output logic [`INDEX_W-1:0]  sram_index,
    output logic [`OFFSET_W-1:0] sram_offset,
    output logic                 sram_r_en,
    output logic                 sram_w_en,
    output logic [`DATA_W-1:0]   sram_w_data,
    output logic [`STRB_W-1:0]   sram_w_strb,
    input  logic [`DATA_W-1:0]   sram_r_data,
    output logic                 mem_req_valid,
    output mem_req_t             mem_req,
    input  logic [`DATA_W-1:0]   mem_rdata       // One cycle after a read
);

    localparam int CNT_W = $clog2(`WORDS_PER_BLOCK);
    localparam int BYTE_W = $clog2(`STRB_W);     // Byte bits of a word address
    localparam logic [7:0] LFSR_SEED = 8'hA5;

    ctrl_state_e        state_q, state_d;
    logic [CNT_W-1:0]   cnt_q, cnt_d;            // Word within block
    logic [7:0]         lfsr_q;
    cache_req_t         req_q;
    logic [`WAY_W-1:0]  way_q;                   // Way being filled
    logic [`TAG_W-1:0]  victim_tag_q;
    logic               in_lookup;
    logic               miss;
    logic               last_word;
    logic [`ADDR_W-1:0] wb_addr;                 // Byte address of victim word
    logic [`ADDR_W-1:0] fill_addr;               // Byte address of refill word

    assign in_lookup = (state_q == LOOKUP);
    assign miss      = in_lookup && !hit;
    assign last_word = (cnt_q == CNT_W'(`WORDS_PER_BLOCK - 1));

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            IDLE: if (req_valid) state_d = LOOKUP;
            LOOKUP: begin
                cnt_d = '0;
                if (hit) begin
                    state_d = RESPOND;
                end else if (victim_entry.valid && victim_entry.dirty) begin
                    state_d = WB_READ;           // Save dirty victim first
                end else begin
                    state_d = REFILL;
                end
            end
            WB_READ: state_d = WB_WRITE;
            WB_WRITE: begin
                cnt_d   = cnt_q + 1'b1;
                state_d = last_word ? REFILL : WB_READ;
            end
            REFILL: state_d = REFILL_WAIT;
            REFILL_WAIT: begin
                cnt_d   = cnt_q + 1'b1;
                state_d = last_word ? LOOKUP : REFILL;  // Replay hits now
            end
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            lfsr_q  <= LFSR_SEED;                // Must be nonzero
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            if (miss) begin
                lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid) begin
            req_q <= req;
        end
        if (miss) begin
            way_q        <= victim_way;          // Fixed before LFSR steps
            victim_tag_q <= victim_entry.tag;
        end
    end

    assign lfsr_bits   = lfsr_q[`WAY_W-1:0];
    assign lookup_addr = req_q.addr;
    assign busy        = (state_q != IDLE);
    assign resp_valid  = (state_q == RESPOND);
    assign resp.rdata  = sram_r_data;            // Read word or merged write

    // Data array addresses the request word in LOOKUP and walks the block otherwise
    assign sram_way    = in_lookup ? hit_way : way_q;
    assign sram_index  = `ADDR_INDEX(req_q.addr);
    assign sram_offset = in_lookup ? `ADDR_OFFSET(req_q.addr) : {cnt_q, {BYTE_W{1'b0}}};
    assign sram_r_en   = (in_lookup && hit && !req_q.write) || (state_q == WB_READ);
    assign sram_w_en   = (in_lookup && hit && req_q.write) || (state_q == REFILL_WAIT);
    assign sram_w_data = in_lookup ? req_q.wdata : mem_rdata;
    assign sram_w_strb = in_lookup ? req_q.wstrb : '1;   // Refill writes whole word

    // Tag update on store hit or at end of refill
    assign tag_we           = (in_lookup && hit && req_q.write)
                           || (state_q == REFILL_WAIT && last_word);
    assign tag_way          = in_lookup ? hit_way : way_q;
    assign tag_wentry.valid = 1'b1;
    assign tag_wentry.dirty = in_lookup;         // Clean after refill
    assign tag_wentry.tag   = `ADDR_TAG(req_q.addr);

    assign wb_addr   = {victim_tag_q, `ADDR_INDEX(req_q.addr), cnt_q, {BYTE_W{1'b0}}};
    assign fill_addr = {req_q.addr[`ADDR_W-1:`OFFSET_W], cnt_q, {BYTE_W{1'b0}}};

    assign mem_req_valid = (state_q == WB_WRITE) || (state_q == REFILL);
    assign mem_req.write = (state_q == WB_WRITE);
    assign mem_req.addr  = mem_req.write ? wb_addr[BYTE_W +: `MEM_ADDR_W]
                                         : fill_addr[BYTE_W +: `MEM_ADDR_W];
    assign mem_req.wdata = sram_r_data;          // Read in WB_READ

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
// Shared types for the data cache
// Processor request/response, backing memory port, tag entry and FSM states
`include "cache_defs.svh"
`default_nettype none

package cache_pkg;

    // Processor request, held by the controller for the whole access
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;        // Byte address
        logic               write;       // 1 = store
        logic [`DATA_W-1:0] wdata;       // Store data
        logic [`STRB_W-1:0] wstrb;       // Byte enables
    } cache_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rdata;       // Load data or merged store word
    } cache_resp_t;

    // Word-wide backing memory access
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;    // Word address, byte addr[15:3]
        logic                   write;   // 1 = write, 0 = read
        logic [`DATA_W-1:0]     wdata;   // Write-back data
    } mem_req_t;

    // Tag format [23] v, [22] d, [21:0] addr[31:10]
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [`TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WB_READ, WB_WRITE, REFILL, REFILL_WAIT, RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

/* design/cache_sram.sv */
// Cache data array, four 128-bit macros with one per 16-byte quarter of a block
// Rows are {way, index}; 64-bit lane picked by offset, byte strobes widened to bits
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module cache_sram (
    input  logic                 clk,
    input  logic [`WAY_W-1:0]    way,
    input  logic [`INDEX_W-1:0]  index,
    input  logic [`OFFSET_W-1:0] offset,
    input  logic                 sram_r_en,
    input  logic                 sram_w_en,
    input  logic [`DATA_W-1:0]   sram_w_data,
    input  logic [`STRB_W-1:0]   sram_w_strb,  // One bit per byte
    output logic [`DATA_W-1:0]   sram_r_data
);

    localparam int LANES  = `CACHE_BLOCK_BYTES / 16;  // Macros per block
    localparam int LANE_W = 128;

    logic [LANES-1:0]  lane_we;               // Active high, one-hot
    logic [`DATA_W-1:0] strb_bits;            // Strobe widened to bits
    logic [LANE_W-1:0] bit_mask;              // Active high write mask
    logic [LANE_W-1:0] lane_q [LANES];        // Macro outputs
    logic [`OFFSET_W-1:3] offset_q;           // Lane and half of last access
    logic              cen;

    assign cen     = ~(sram_r_en | sram_w_en);  // All macros on for any access
    assign lane_we = sram_w_en ? ({{(LANES-1){1'b0}}, 1'b1} << offset[5:4]) : '0;

    always_comb begin
        for (int b = 0; b < `STRB_W; b++) begin
            strb_bits[b*8 +: 8] = {8{sram_w_strb[b]}};
        end
    end

    assign bit_mask = offset[3] ? {strb_bits, {`DATA_W{1'b0}}}
                                : {{`DATA_W{1'b0}}, strb_bits};  // Upper or lower half

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        sram_1p_128x32 u_sram (
            .clk  (clk),
            .cen  (cen),
            .wen  (~lane_we[i]),
            .bwen (~bit_mask),
            .a    ({way, index}),
            .d    ({2{sram_w_data}}),           // Same word in both halves
            .q    (lane_q[i])
        );
    end

    // Holds the select stable while the address moves on
    always_ff @(posedge clk) begin
        if (sram_r_en | sram_w_en) begin
            offset_q <= offset[5:3];
        end
    end

    assign sram_r_data = offset_q[3] ? lane_q[offset_q[5:4]][LANE_W-1:`DATA_W]
                                     : lane_q[offset_q[5:4]][`DATA_W-1:0];

endmodule

`default_nettype wire

/* design/cache_tag_array.sv */
// Tag store for 4 ways x 16 sets with valid and dirty bits
// Combinational hit detection and victim choice of the first free way or the LFSR way
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module cache_tag_array import cache_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [`ADDR_W-1:0]  lookup_addr,   // Registered request address
    input  logic                tag_we,
    input  logic [`WAY_W-1:0]   tag_way,
    input  tag_entry_t          tag_wentry,
    input  logic [`WAY_W-1:0]   lfsr_bits,     // Random way for full sets
    output logic                hit,
    output logic [`WAY_W-1:0]   hit_way,
    output logic [`WAY_W-1:0]   victim_way,
    output tag_entry_t          victim_entry
);

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty_q;
    logic [`TAG_W-1:0] tag_q [`CACHE_SETS][`CACHE_WAYS];  // Stored addr[31:10] per way

    logic [`INDEX_W-1:0]    idx;
    logic [`TAG_W-1:0]      req_tag;
    logic [`CACHE_WAYS-1:0] way_hit;

    assign idx     = `ADDR_INDEX(lookup_addr);  // Set for lookup and tag write
    assign req_tag = `ADDR_TAG(lookup_addr);

    always_comb begin
        hit_way    = '0;
        victim_way = lfsr_bits;                   // Set full, random pick
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == req_tag);
            if (way_hit[w]) begin
                hit_way = `WAY_W'(w);
            end
            if (!valid_q[idx][w]) begin
                victim_way = `WAY_W'(w);          // Lowest free way wins
            end
        end
        hit = |way_hit;
    end

    always_comb begin
        victim_entry.valid = valid_q[idx][victim_way];
        victim_entry.dirty = dirty_q[idx][victim_way];
        victim_entry.tag   = tag_q[idx][victim_way];  // Write-back address
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;                        // All ways invalid
            dirty_q <= '0;
        end else if (tag_we) begin
            valid_q[idx][tag_way] <= tag_wentry.valid;
            dirty_q[idx][tag_way] <= tag_wentry.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_q[idx][tag_way] <= tag_wentry.tag;
        end
    end

endmodule

`default_nettype wire

/* design/cache_top.sv */
// Data cache top level with tag array, data array, controller and backing memory
// Only the processor port is visible outside
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    input  cache_req_t  req,
    output logic        resp_valid,
    output cache_resp_t resp,
    output logic        busy
);

    logic [`ADDR_W-1:0]   lookup_addr;
    logic                 hit;
    logic [`WAY_W-1:0]    hit_way;
    logic [`WAY_W-1:0]    victim_way;
    tag_entry_t           victim_entry;
    logic                 tag_we;
    logic [`WAY_W-1:0]    tag_way;
    tag_entry_t           tag_wentry;
    logic [`WAY_W-1:0]    lfsr_bits;
    logic [`WAY_W-1:0]    sram_way;
    logic [`INDEX_W-1:0]  sram_index;
    logic [`OFFSET_W-1:0] sram_offset;
    logic                 sram_r_en;
    logic                 sram_w_en;
    logic [`DATA_W-1:0]   sram_w_data;
    logic [`STRB_W-1:0]   sram_w_strb;
    logic [`DATA_W-1:0]   sram_r_data;
    logic                 mem_req_valid;
    mem_req_t             mem_req;
    logic [`DATA_W-1:0]   mem_rdata;

    cache_tag_array u_tag_array (
        .clk (clk), .arst_n (arst_n), .lookup_addr (lookup_addr),
        .tag_we (tag_we), .tag_way (tag_way), .tag_wentry (tag_wentry),
        .lfsr_bits (lfsr_bits), .hit (hit), .hit_way (hit_way),
        .victim_way (victim_way), .victim_entry (victim_entry)
    );

    cache_sram u_cache_sram (
        .clk (clk), .way (sram_way), .index (sram_index), .offset (sram_offset),
        .sram_r_en (sram_r_en), .sram_w_en (sram_w_en), .sram_w_data (sram_w_data),
        .sram_w_strb (sram_w_strb), .sram_r_data (sram_r_data)
    );

    cache_ctrl u_cache_ctrl (
        .clk (clk), .arst_n (arst_n), .req_valid (req_valid), .req (req),
        .resp_valid (resp_valid), .resp (resp), .busy (busy),
        .lookup_addr (lookup_addr), .hit (hit), .hit_way (hit_way),
        .victim_way (victim_way), .victim_entry (victim_entry),
        .tag_we (tag_we), .tag_way (tag_way), .tag_wentry (tag_wentry),
        .lfsr_bits (lfsr_bits), .sram_way (sram_way), .sram_index (sram_index),
        .sram_offset (sram_offset), .sram_r_en (sram_r_en), .sram_w_en (sram_w_en),
        .sram_w_data (sram_w_data), .sram_w_strb (sram_w_strb),
        .sram_r_data (sram_r_data), .mem_req_valid (mem_req_valid),
        .mem_req (mem_req), .mem_rdata (mem_rdata)
    );

    main_mem u_main_mem (
        .clk (clk), .mem_req_valid (mem_req_valid), .mem_req (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* design/main_mem.sv */
// Backing memory below the cache holding 64 KB as 8192 words of 64 bits
// Writes land at the clock edge, read data is registered one cycle after the strobe
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module main_mem import cache_pkg::*; (
    input  logic               clk,
    input  logic               mem_req_valid,
    input  mem_req_t           mem_req,
    output logic [`DATA_W-1:0] mem_rdata
);

    localparam int MEM_WORDS = 1 << `MEM_ADDR_W;

    logic [`DATA_W-1:0] mem [MEM_WORDS];         // Word storage
    logic               rd_stb;
    logic               wr_stb;

    // Every word starts out zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_stb = mem_req_valid && !mem_req.write;
    assign wr_stb = mem_req_valid && mem_req.write;

    always_ff @(posedge clk) begin
        if (wr_stb) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            mem_rdata <= mem[mem_req.addr];     // Held until the next read
        end
    end

endmodule

`default_nettype wire

/* design/sram_1p_128x32.sv */
// Single-port 128-bit SRAM macro model, 64 rows in a 32x2 arrangement
// Active-low chip and write enables, active-low per-bit write mask, registered Q
`timescale 1ns/1ps
`default_nettype none

module sram_1p_128x32 (
    input  logic         clk,
    input  logic         cen,     // Chip enable, low active
    input  logic         wen,     // Write enable, low active
    input  logic [127:0] bwen,    // Bit write mask, low = write bit
    input  logic [5:0]   a,       // {way, index}
    input  logic [127:0] d,
    output logic [127:0] q
);

    logic [127:0] mem [64];       // Row storage
    logic [127:0] merged;         // Row after masked write

    assign merged = (mem[a] & bwen) | (d & ~bwen);   // Masked bits keep old value

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= merged;
                q      <= merged; // Write-through on Q
            end else begin
                q      <= mem[a];
            end
        end
    end

endmodule

`default_nettype wire

/* include/cache_defs.svh */
// Cache geometry and address field widths for the 4 KB, 4-way data cache
// Also sizes the word-wide backing memory under the top level
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_WAYS        4                     // Ways per set
`define CACHE_SETS        16                    // Sets (index range)
`define CACHE_BLOCK_BYTES 64                    // Bytes per block
`define WAY_W             $clog2(`CACHE_WAYS)   // Way select width

`define ADDR_W            32                    // Byte address
`define DATA_W            64                    // Processor word
`define TAG_W             22                    // addr[31:10]
`define INDEX_W           4                     // addr[9:6]
`define OFFSET_W          6                     // addr[5:0]
`define STRB_W            8                     // One strobe per byte

`define WORDS_PER_BLOCK   8                     // 64-bit words in a block
`define MEM_ADDR_W        13                    // Backing memory word address

// Address field extraction
`define ADDR_TAG(a)       a[`ADDR_W-1 -: `TAG_W]
`define ADDR_INDEX(a)     a[`OFFSET_W +: `INDEX_W]
`define ADDR_OFFSET(a)    a[`OFFSET_W-1:0]

`endif

/* verif/cache_props.sv */
// Handshake, refill and response checks bound into the cache controller
// Strobe only when idle, lookup after accept, hit on replay and known response data
`timescale 1ns/1ps
`default_nettype none

module cache_props import cache_pkg::*; (
    input logic        clk,
    input logic        arst_n,
    input logic        req_valid,
    input logic        resp_valid,
    input logic        busy,
    input logic        hit,
    input cache_resp_t resp,
    input ctrl_state_e state_q
);

    // Requester must hold off while an access is in flight
    strobe_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> !busy)
        else $error("request strobe while the cache is busy");

    accept_to_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |=> (busy && state_q == LOOKUP))     // Lookup starts next cycle
        else $error("accepted request did not enter lookup");

    // Tag installed at the end of refill must match on the replayed lookup
    replay_hits: assert property (@(posedge clk) disable iff (!arst_n)
        (state_q == LOOKUP && $past(state_q) == REFILL_WAIT) |-> hit)
        else $error("lookup after refill did not hit");

    resp_data_known: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> !$isunknown(resp))              // Read of a filled line
        else $error("response data unknown while the response strobe is high");

endmodule

`default_nettype wire

/* verif/tb_cache.sv */
// Testbench for the data cache with random requests checked against a flat byte model
// Zero reads, strobed writes, hit latency, eviction rounds and mixed traffic
`timescale 1ns/1ps
`include "cache_defs.svh"
`default_nettype none

module tb_cache import cache_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int SEED            = 66732;
    localparam int N_ZERO          = 8;        // Reads of untouched words
    localparam int N_WRITE         = 16;       // Write then read-back pairs
    localparam int N_ROUNDS        = 3;
    localparam int N_TAGS          = 6;        // More tags than ways in one set
    localparam int EVICT_INDEX     = 5;
    localparam int N_RANDOM        = 300;      // Each may add a repeat read
    localparam int REQ_COUNT       = N_ZERO + 2 * N_WRITE + 2 * N_ROUNDS * N_TAGS
                                   + 2 * N_RANDOM;
    localparam int WATCHDOG_CYCLES = REQ_COUNT * 40 + RESET_CYCLES;
    localparam int MODEL_BYTES     = 1 << 16;  // Same span as backing memory

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    cache_req_t  req;
    logic        resp_valid;
    cache_resp_t resp;
    logic        busy;

    logic [7:0]  model_mem [MODEL_BYTES];      // Reference byte memory
    logic [31:0] lcg_state;
    int          checks;
    int          errors;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cache_top dut (
        .clk (clk), .arst_n (arst_n), .req_valid (req_valid), .req (req),
        .resp_valid (resp_valid), .resp (resp), .busy (busy)
    );

    bind cache_ctrl cache_props u_props (
        .clk (clk), .arst_n (arst_n), .req_valid (req_valid), .resp_valid (resp_valid),
        .busy (busy), .hit (hit), .resp (resp), .state_q (state_q)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Little-endian word from the byte model
    function automatic logic [63:0] model_read(input logic [31:0] addr);
        logic [63:0] word;
        for (int b = 0; b < `STRB_W; b++) begin
            word[b*8 +: 8] = model_mem[addr[15:0] + 16'(b)];
        end
        return word;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [63:0] wdata,
                               input logic [7:0] wstrb);
        for (int b = 0; b < `STRB_W; b++) begin
            if (wstrb[b]) begin
                model_mem[addr[15:0] + 16'(b)] = wdata[b*8 +: 8];  // Strobed bytes only
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] addr,
                                 input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s at %h: expected %h, actual %h", name, addr, expected, actual);
        end
    endtask

    // Issues one request and waits for its response, entered and left 1 ns past an edge
    task automatic access(input logic [31:0] addr, input logic write,
                          input logic [63:0] wdata, input logic [7:0] wstrb,
                          output logic [63:0] rdata, output int latency);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req       = '{addr: addr, write: write, wdata: wdata, wstrb: wstrb};
        @(posedge clk);
        #1;
        req_valid = 1'b0;                      // Single-cycle strobe
        latency   = 1;
        while (!resp_valid) begin
            @(posedge clk);
            #1;
            latency++;
        end
        rdata = resp.rdata;
    endtask

    task automatic checked_access(input string name, input logic [31:0] addr,
                                  input logic write, input logic [63:0] wdata,
                                  input logic [7:0] wstrb, output int latency);
        logic [63:0] expected;
        logic [63:0] actual;
        if (write) begin
            model_write(addr, wdata, wstrb);
        end
        expected = model_read(addr);           // Merged word for a store
        access(addr, write, wdata, wstrb, actual, latency);
        compare_value(name, addr, expected, actual);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] addr;
        logic [63:0] wdata;
        int          lat;
        req_valid = 1'b0;
        req       = '0;
        lcg_state = 32'(SEED);
        checks    = 0;
        errors    = 0;
        for (int i = 0; i < MODEL_BYTES; i++) begin
            model_mem[i] = '0;                 // Matches zeroed backing memory
        end
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        checks++;
        assert (!busy) else begin
            errors++;
            $display("busy is high after reset before any request");
        end

        for (int i = 0; i < N_ZERO; i++) begin
            r    = lcg_next();
            addr = {16'h0, r[31:19], 3'b000};  // Any word of the 64 KB
            checked_access("zero read", addr, 1'b0, '0, '0, lat);
        end

        for (int i = 0; i < N_WRITE; i++) begin
            r     = lcg_next();
            addr  = {18'h0, r[26:16], 3'b000};
            wdata = {lcg_next(), lcg_next()};
            s     = lcg_next();
            checked_access("strobed write", addr, 1'b1, wdata, s[23:16], lat);
            checked_access("read after write", addr, 1'b0, '0, '0, lat);
            compare_value("hit latency", addr, 64'd2, 64'(lat));
        end

        // Six tags on one set force evictions and dirty write-backs
        for (int rnd = 0; rnd < N_ROUNDS; rnd++) begin
            for (int t = 0; t < N_TAGS; t++) begin
                addr  = 32'(t * 1024 + EVICT_INDEX * 64 + ((t * 3) % 8) * 8);
                wdata = {lcg_next(), lcg_next()};
                s     = lcg_next();
                checked_access("eviction read", addr, 1'b0, '0, '0, lat);
                checked_access("eviction write", addr, 1'b1, wdata, s[23:16], lat);
            end
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r     = lcg_next();
            addr  = {18'h0, r[26:16], 3'b000};  // 16 KB window
            wdata = {lcg_next(), lcg_next()};
            s     = lcg_next();
            checked_access("mixed traffic", addr, r[31], wdata, s[23:16], lat);
            if (s[29:28] == 2'b00) begin       // About a quarter repeat at once
                checked_access("repeat read", addr, 1'b0, '0, '0, lat);
                compare_value("repeat hit latency", addr, 64'd2, 64'(lat));
            end
        end

        @(posedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// Testbench clock and reset source
// Free-running clock, arst_n held low for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 100,          // Clock period in ns
    parameter int RESET_CYCLES = 16            // Cycles with reset asserted
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;                         // Reset asserted from time 0
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;                         // Released just after an edge
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/cache_pkg.sv
design/sram_1p_128x32.sv
design/cache_sram.sv
design/cache_tag_array.sv
design/cache_ctrl.sv
design/main_mem.sv
design/cache_top.sv
verif/tb_clk_gen.sv
verif/cache_props.sv
verif/tb_cache.sv
